// ==== bench/uart_golden.txt ====
// columns: op  repeat  byte  expect   (hex, byte and expect step by one per repeat)
// op 01 send, 02 inject, 03 inject_bad, 04 pop, 05 clear, 06 expect_status (byte = mask),
//    07 watch tx, 08 expect irq, 09 pop on empty, 0f end of test (byte = number), 00 end
01 01 a5 00
01 02 3c 00
01 01 80 00
07 01 00 a5
07 02 00 3c
07 01 00 80
0f 01 01 00
02 01 5a 00
02 02 00 00
02 01 ff 00
04 01 00 5a
04 02 00 00
04 01 00 ff
06 01 01 00
0f 01 02 00
03 01 c3 00
06 01 09 08
08 01 00 01
05 01 00 00
06 01 08 00
08 01 00 00
0f 01 03 00
02 11 10 00
06 01 11 11
04 10 00 10
06 01 11 10
05 01 00 00
0f 01 04 00
09 01 00 00
06 01 20 20
05 01 00 00
06 01 20 00
01 01 e0 00
01 11 40 00
06 01 46 46
07 01 00 e0
07 10 00 40
06 01 04 00
05 01 00 00
06 01 ff 00
0f 01 05 00
00 00 00 00

// ==== uart_and_fifo.f ====
common/uart_pkg.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
fifo/byte_fifo.sv
hdl/uart_status.sv
hdl/uart_and_fifo.sv
bench/uart_and_fifo_properties.sv
bench/uart_and_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: uart_and_fifo

sources:
  # shared package first
  - common/uart_pkg.sv
  - uart_rx/uart_rx.sv
  - uart_tx/uart_tx.sv
  - fifo/byte_fifo.sv
  - hdl/uart_status.sv
  - hdl/uart_and_fifo.sv

  # testbench, top module uart_and_fifo_tb
  - target: test
    files:
      - bench/uart_and_fifo_properties.sv
      - bench/uart_and_fifo_tb.sv

// ==== bench/uart_and_fifo_tb.sv ====
`default_nettype none

module uart_and_fifo_tb
    import uart_pkg::*;
();

    localparam int MAX_OPS     = 64;    // golden lines of four words
    localparam int RX_WAIT     = 250;   // cycles for rx_ready
    localparam int TX_WAIT     = 400;   // cycles for one decoded tx frame
    localparam int STATUS_WAIT = 40;    // cycles for a status or irq value

    logic       clock = 1'b0;
    logic       reset;
    logic       rx;
    logic       tx;
    logic       tx_write;
    uart_byte_t tx_data;
    logic       rx_read;
    uart_byte_t rx_data;
    logic       rx_ready;
    logic       clear_errors;
    uart_byte_t status;
    logic       irq;

    uart_byte_t golden [0:4*MAX_OPS-1];   // op, repeat, byte, expect
    uart_byte_t tx_seen [$];              // bytes decoded off the tx line
    integer     seed = 32'h4e7d367e;
    int         tests, checks, errors;
    int         test_checks, test_errors;

    always #10 clock = ~clock;            // period 20

    uart_and_fifo u_dut (
        .clock        (clock),
        .reset        (reset),
        .rx           (rx),
        .tx           (tx),
        .tx_write     (tx_write),
        .tx_data      (tx_data),
        .rx_read      (rx_read),
        .rx_data      (rx_data),
        .rx_ready     (rx_ready),
        .clear_errors (clear_errors),
        .status       (status),
        .irq          (irq)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic check_value(input string name, input uart_byte_t got, input uart_byte_t want);
        checks++;
        test_checks++;
        if (got !== want) begin
            $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, want);
            errors++;
            test_errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("%0d tests, %0d checks, %0d errors, run stopped", tests, checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic next_drive_slot();
        @(posedge clock);
        #2;                                // just after the edge
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap + 1) @(posedge clock);
    endtask

    task automatic push_tx(input uart_byte_t b);
        next_drive_slot();
        tx_write = 1'b1;
        tx_data  = b;
        next_drive_slot();
        tx_write = 1'b0;
    endtask

    // start, eight data bits low first, stop
    task automatic drive_rx_frame(input uart_byte_t b, input logic stop_level);
        logic [9:0] frame;
        frame = {stop_level, b, 1'b0};
        next_drive_slot();
        for (int k = 0; k < 10; k++) begin
            rx = frame[k];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
            next_drive_slot();             // bit held CLKS_PER_BIT cycles
        end
        rx = 1'b1;
    endtask

    // decodes every tx frame for the whole run
    task automatic watch_tx_line();
        logic       last;
        uart_byte_t b;
        last = 1'b1;
        forever begin
            @(negedge clock);
            if (last && !tx) begin
                repeat (HALF_BIT - 1) @(negedge clock);   // mid start bit
                check_value("tx start bit", tx, 8'h00);
                for (int k = 0; k < 8; k++) begin
                    repeat (CLKS_PER_BIT) @(negedge clock);
                    b[k] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clock);
                check_value("tx stop bit", tx, 8'h01);
                tx_seen.push_back(b);
            end
            last = tx;
        end
    endtask

    task automatic pop_rx(input uart_byte_t want);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!rx_ready && cycles < RX_WAIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!rx_ready) begin
            abort_run("rx_ready never rose for a received byte");
        end else begin
            check_value("rx_data", rx_data, want);
            next_drive_slot();
            rx_read = 1'b1;
            next_drive_slot();
            rx_read = 1'b0;
        end
    endtask

    task automatic expect_tx_byte(input uart_byte_t want);
        int cycles;
        cycles = 0;
        while (tx_seen.size() == 0 && cycles < TX_WAIT) begin
            @(negedge clock);
            cycles++;
        end
        if (tx_seen.size() == 0) abort_run("no frame appeared on tx");
        else check_value("tx byte", tx_seen.pop_front(), want);
    endtask

    // status is registered and may need a few cycles
    task automatic expect_status(input uart_byte_t mask, input uart_byte_t want);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while ((status & mask) !== want && cycles < STATUS_WAIT) begin
            @(negedge clock);
            cycles++;
        end
        check_value("status", status & mask, want);
    endtask

    task automatic expect_irq(input logic want);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (irq !== want && cycles < STATUS_WAIT) begin
            @(negedge clock);
            cycles++;
        end
        check_value("irq", irq, want);
    endtask

    task automatic run_op(input uart_byte_t op, input uart_byte_t value, input uart_byte_t want);
        case (op)
            8'h01: push_tx(value);
            8'h02: drive_rx_frame(value, 1'b1);
            8'h03: drive_rx_frame(value, 1'b0);     // zero stop bit
            8'h04: pop_rx(want);
            8'h05: begin
                next_drive_slot();
                clear_errors = 1'b1;
                next_drive_slot();
                clear_errors = 1'b0;
            end
            8'h06: expect_status(value, want);      // value is the mask
            8'h07: expect_tx_byte(want);
            8'h08: expect_irq(want[0]);
            8'h09: begin                            // pop with nothing queued
                next_drive_slot();
                rx_read = 1'b1;
                next_drive_slot();
                rx_read = 1'b0;
            end
            8'h0f: begin
                $display("test %0d: %0d checks, %0d errors", value, test_checks, test_errors);
                tests++;
                test_checks = 0;
                test_errors = 0;
            end
            default: begin
                $display("golden file holds an unknown operation code %02h", op);
                errors++;
            end
        endcase
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int         idx;
        uart_byte_t op, rpt, value, want;
        reset        = 1'b1;
        rx           = 1'b1;                        // line idle
        tx_write     = 1'b0;
        tx_data      = '0;
        rx_read      = 1'b0;
        clear_errors = 1'b0;
        $readmemh("bench/uart_golden.txt", golden);
        repeat (16) @(posedge clock);
        #2 reset = 1'b0;
        fork
            watch_tx_line();
        join_none
        idx = 0;
        while (idx < MAX_OPS && golden[4*idx] != 8'h00) begin
            op    = golden[4*idx];
            rpt   = golden[4*idx + 1];
            value = golden[4*idx + 2];
            want  = golden[4*idx + 3];
            for (int n = 0; n < rpt; n++) begin     // byte and expect step per repeat
                run_op(op, uart_byte_t'(value + n), uart_byte_t'(want + n));
            end
            if (op != 8'h01) idle_gap();            // pushes go out back to back
            idx++;
        end
        errors = errors + u_dut.u_properties.failures;   // bound assertion failures
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/uart_and_fifo_properties.sv ====
`default_nettype none

module uart_and_fifo_properties
    import uart_pkg::*;
(
    input wire logic       clock,
    input wire logic       reset,
    input wire logic       tx,
    input wire logic       tx_active,
    input wire logic       tx_take,
    input wire logic       rx_received,
    input wire logic       frame_error,
    input wire logic       rx_ready,
    input wire uart_byte_t status,
    input wire logic       irq
);

    int failures = 0;   // assertion failures so far

    // line idles high between frames
    assert property (@(posedge clock) disable iff (reset) !tx_active |-> tx)
        else begin
            failures++;
            $error("tx line low while no frame is active");
        end

    ////////////////////
    // single cycle pulses
    ////////////////////

    assert property (@(posedge clock) disable iff (reset) tx_take |=> !tx_take)
        else begin
            failures++;
            $error("take held for two cycles");
        end

    assert property (@(posedge clock) disable iff (reset) rx_received |=> !rx_received)
        else begin
            failures++;
            $error("received held for two cycles");
        end

    assert property (@(posedge clock) disable iff (reset) frame_error |=> !frame_error)
        else begin
            failures++;
            $error("frame_error held for two cycles");
        end

    // irq only with a cause visible
    assert property (@(posedge clock) disable iff (reset) (status == '0 && !rx_ready) |-> !irq)
        else begin
            failures++;
            $error("irq high with empty status and no rx byte");
        end

endmodule

bind uart_and_fifo uart_and_fifo_properties u_properties (
    .clock, .reset, .tx, .tx_active, .tx_take, .rx_received,
    .frame_error, .rx_ready, .status, .irq
);

`default_nettype wire

// ==== hdl/uart_and_fifo.sv ====
`default_nettype none

module uart_and_fifo
    import uart_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       rx,             // serial in
    output logic            tx,             // serial out
    input  wire logic       tx_write,       // push tx_data
    input  wire uart_byte_t tx_data,
    input  wire logic       rx_read,        // pop rx_data
    output uart_byte_t      rx_data,        // rx queue head
    output logic            rx_ready,
    input  wire logic       clear_errors,
    output uart_byte_t      status,
    output logic            irq
);

    ////////////////////
    // receive path
    ////////////////////

    uart_byte_t  rx_byte;        // receiver to queue
    logic        rx_received;
    logic        frame_error;
    logic        rx_overflow;
    logic        rx_underflow;

    uart_rx u_uart_rx (
        .clock       (clock),
        .reset       (reset),
        .rx          (rx),
        .rx_byte     (rx_byte),
        .received    (rx_received),
        .frame_error (frame_error)
    );

    byte_fifo #(.size_log2(FIFO_SIZE_LOG2)) u_rx_fifo (
        .clock      (clock),
        .reset      (reset),
        .write      (rx_received),
        .byte_in    (rx_byte),
        .read_next  (rx_read),
        .byte_out   (rx_data),
        .data_ready (rx_ready),
        .count      (),          // fill not reported on rx side
        .overflow   (rx_overflow),
        .underflow  (rx_underflow)
    );

    ////////////////////
    // transmit path
    ////////////////////

    uart_byte_t  tx_byte;        // queue head to transmitter
    logic        tx_ready;
    logic        tx_take;
    logic        tx_active;
    fifo_count_t tx_count;
    logic        tx_overflow;

    byte_fifo #(.size_log2(FIFO_SIZE_LOG2)) u_tx_fifo (
        .clock      (clock),
        .reset      (reset),
        .write      (tx_write),
        .byte_in    (tx_data),
        .read_next  (tx_take),
        .byte_out   (tx_byte),
        .data_ready (tx_ready),
        .count      (tx_count),
        .overflow   (tx_overflow),
        .underflow  ()           // uart_tx only takes when ready
    );

    uart_tx u_uart_tx (
        .clock      (clock),
        .reset      (reset),
        .data_ready (tx_ready),
        .tx_data    (tx_byte),
        .take       (tx_take),
        .active     (tx_active),
        .tx         (tx)
    );

    ////////////////////
    // status and irq
    ////////////////////

    uart_status u_uart_status (
        .clock        (clock),
        .reset        (reset),
        .clear_errors (clear_errors),
        .frame_error  (frame_error),
        .rx_overflow  (rx_overflow),
        .rx_underflow (rx_underflow),
        .tx_overflow  (tx_overflow),
        .rx_ready     (rx_ready),
        .tx_count     (tx_count),
        .tx_active    (tx_active),
        .status       (status),
        .irq          (irq)
    );

endmodule

`default_nettype wire

// ==== hdl/uart_status.sv ====
`default_nettype none

module uart_status
    import uart_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        clear_errors,   // drops all sticky flags
    input  wire logic        frame_error,    // pulses from the paths
    input  wire logic        rx_overflow,
    input  wire logic        rx_underflow,
    input  wire logic        tx_overflow,
    input  wire logic        rx_ready,       // levels
    input  wire fifo_count_t tx_count,
    input  wire logic        tx_active,
    output uart_byte_t       status,
    output logic             irq
);

    logic       framing_flag;     // sticky copies
    logic       rx_ovf_flag;
    logic       rx_unf_flag;
    logic       tx_ovf_flag;
    uart_byte_t status_next;

    // clear beats a same-cycle error
    always_comb begin
        status_next                  = '0;
        status_next[ST_RX_READY]     = rx_ready;
        status_next[ST_TX_FULL]      = (tx_count == fifo_count_t'(FIFO_DEPTH));
        status_next[ST_TX_ACTIVE]    = tx_active;
        status_next[ST_FRAMING]      = !clear_errors && (framing_flag || frame_error);
        status_next[ST_RX_OVERFLOW]  = !clear_errors && (rx_ovf_flag || rx_overflow);
        status_next[ST_RX_UNDERFLOW] = !clear_errors && (rx_unf_flag || rx_underflow);
        status_next[ST_TX_OVERFLOW]  = !clear_errors && (tx_ovf_flag || tx_overflow);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            framing_flag <= 1'b0;
            rx_ovf_flag  <= 1'b0;
            rx_unf_flag  <= 1'b0;
            tx_ovf_flag  <= 1'b0;
            status       <= '0;
            irq          <= 1'b0;
        end else begin
            framing_flag <= status_next[ST_FRAMING];
            rx_ovf_flag  <= status_next[ST_RX_OVERFLOW];
            rx_unf_flag  <= status_next[ST_RX_UNDERFLOW];
            tx_ovf_flag  <= status_next[ST_TX_OVERFLOW];
            status       <= status_next;
            // any error or a byte waiting
            irq <= |status_next[ST_TX_OVERFLOW:ST_FRAMING] || rx_ready;
        end
    end

endmodule

`default_nettype wire

// ==== fifo/byte_fifo.sv ====
`default_nettype none

module byte_fifo
    import uart_pkg::*;
#(
    parameter int size_log2 = FIFO_SIZE_LOG2      // depth is 2**size_log2
)(
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          write,         // push byte_in
    input  wire uart_byte_t    byte_in,
    input  wire logic          read_next,     // pop the head
    output uart_byte_t         byte_out,      // head byte, prefetched
    output logic               data_ready,    // byte_out is valid
    output logic [size_log2:0] count,         // bytes held, full reads as depth
    output logic               overflow,      // one cycle, push dropped
    output logic               underflow      // one cycle, pop on empty
);

    uart_byte_t           mem [2**size_log2];  // circular buffer
    logic [size_log2-1:0] head;                // next byte out
    logic [size_log2-1:0] tail;                // next free slot
    logic [size_log2-1:0] head_next;           // head + 1, wraps
    logic                 full;
    logic                 write_ok;
    logic                 read_ok;

    assign head_next = head + 1'b1;
    assign full      = count[size_log2];       // only set at exactly depth
    assign write_ok  = write && !full;
    assign read_ok   = read_next && data_ready;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (write_ok) mem[tail] <= byte_in;
    end

    ////////////////////
    // pointers and fill
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (write_ok) tail <= tail + 1'b1;   // wraps at power of two
            if (read_ok) head <= head_next;
            if (write_ok && !read_ok) begin
                count <= count + 1'b1;
            end else if (read_ok && !write_ok) begin
                count <= count - 1'b1;
            end
            // push and pop together leave count alone
        end
    end

    ////////////////////
    // output prefetch
    ////////////////////

    // a fresh write to an empty queue shows two cycles later
    always_ff @(posedge clock) begin
        if (reset) begin
            data_ready <= 1'b0;
        end else if (count == '0 || (read_ok && count == 1)) begin
            data_ready <= 1'b0;                  // empty, or last byte leaving
        end else begin
            data_ready <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (read_ok) byte_out <= mem[head_next]; // next in line
        else byte_out <= mem[head];
    end

    ////////////////////
    // error events
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow  <= write && full;
            underflow <= read_next && !data_ready;
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx/uart_tx.sv ====
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       reset,
    input  wire logic       data_ready,   // queue head is valid
    input  wire uart_byte_t tx_data,      // queue head byte
    output logic            take,         // one cycle, pops the queue
    output logic            active,       // frame in progress
    output logic            tx            // serial line out
);

    frame_state_e state;
    bit_timer_t   timer;                  // clocks into current bit
    bit_index_t   bit_index;              // data bit on the line
    uart_byte_t   tx_shift;               // copy of the byte being sent
    logic         bit_end;

    assign bit_end = (timer == bit_timer_t'(CLKS_PER_BIT - 1));

    ////////////////////
    // frame FSM
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            timer     <= '0;
            bit_index <= '0;
            take      <= 1'b0;
            active    <= 1'b0;
            tx        <= 1'b1;                // line idles high
        end else begin
            take <= 1'b0;
            case (state)
                IDLE: begin
                    timer     <= '0;
                    bit_index <= '0;
                    tx        <= 1'b1;
                    if (take) begin           // byte copied this cycle
                        state <= START;
                        tx    <= 1'b0;        // start bit
                    end else if (data_ready) begin
                        take   <= 1'b1;
                        active <= 1'b1;
                    end
                end
                START: begin
                    if (bit_end) begin
                        timer <= '0;
                        tx    <= tx_shift[0]; // low bit first
                        state <= DATA;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        timer <= '0;
                        if (bit_index == 3'd7) begin
                            tx    <= 1'b1;    // stop bit
                            state <= STOP;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                            tx        <= tx_shift[bit_index + bit_index_t'(1)];
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        timer  <= '0;
                        active <= 1'b0;       // at least one idle cycle follows
                        state  <= IDLE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // grab head byte while the queue pops
    always_ff @(posedge clock) begin
        if (take) tx_shift <= tx_data;
    end

endmodule

`default_nettype wire

// ==== uart_rx/uart_rx.sv ====
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic rx,             // serial line in, idles high
    output uart_byte_t rx_byte,       // last byte assembled
    output logic      received,       // one cycle, rx_byte valid
    output logic      frame_error     // one cycle, bad start or stop bit
);

    logic         rx_meta;            // first sync stage
    logic         rx_sync;            // line sample used by the FSM
    logic         rx_last;            // previous sample, edge detect
    frame_state_e state;
    bit_timer_t   timer;              // clocks into current bit
    bit_index_t   bit_index;          // data bit being sampled
    logic         bit_end;            // one full bit time elapsed
    logic         start_edge;         // high to low on the line

    assign bit_end    = (timer == bit_timer_t'(CLKS_PER_BIT - 1));
    assign start_edge = rx_last && !rx_sync;

    ////////////////////
    // line synchronizer
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rx_meta <= 1'b1;          // idle level
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    ////////////////////
    // frame FSM
    ////////////////////

    always_ff @(posedge clock) begin
        received    <= 1'b0;          // both are pulses
        frame_error <= 1'b0;
        if (reset) begin
            state     <= IDLE;
            timer     <= '0;
            bit_index <= '0;
        end else begin
            case (state)
                IDLE: begin
                    timer     <= '0;
                    bit_index <= '0;
                    if (start_edge) state <= START;  // a falling edge, not just low
                end
                START: begin
                    if (timer == bit_timer_t'(HALF_BIT - 1)) begin
                        timer <= '0;              // realign on mid start bit
                        if (!rx_sync) begin
                            state <= DATA;
                        end else begin
                            frame_error <= 1'b1;  // glitch or wrong baud
                            state       <= IDLE;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_end) begin        // middle of a data bit
                        timer     <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) state <= STOP;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_end) begin        // middle of stop bit
                        timer <= '0;
                        state <= IDLE;        // half a bit left to find the next edge
                        if (rx_sync) received <= 1'b1;
                        else frame_error <= 1'b1;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data bits land low first
    always_ff @(posedge clock) begin
        if (state == DATA && bit_end) rx_byte[bit_index] <= rx_sync;
    end

endmodule

`default_nettype wire

// ==== common/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    ////////////////////
    // serial timing
    ////////////////////

    localparam int unsigned CLOCK_FREQUENCY = 1_000_000;     // system clock in Hz, short sims
    localparam int unsigned BAUD_RATE       = 100_000;       // line bit rate
    localparam int unsigned CLKS_PER_BIT    = CLOCK_FREQUENCY / BAUD_RATE;  // 10
    localparam int unsigned HALF_BIT        = CLKS_PER_BIT / 2;  // start bit middle
    localparam int unsigned BIT_TIMER_WIDTH = $clog2(CLKS_PER_BIT);

    ////////////////////
    // widths
    ////////////////////

    localparam int unsigned BYTE_WIDTH     = 8;
    localparam int unsigned FIFO_SIZE_LOG2 = 4;                     // 16 entries
    localparam int unsigned FIFO_DEPTH     = 2 ** FIFO_SIZE_LOG2;

    typedef logic [BYTE_WIDTH-1:0]      uart_byte_t;   // one data byte
    typedef logic [BIT_TIMER_WIDTH-1:0] bit_timer_t;   // clocks within a bit
    typedef logic [2:0]                 bit_index_t;   // data bit number
    typedef logic [FIFO_SIZE_LOG2:0]    fifo_count_t;  // 0 .. FIFO_DEPTH

    // frame position, shared by rx and tx
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } frame_state_e;

    ////////////////////
    // status byte layout
    ////////////////////

    localparam int ST_RX_READY     = 0;   // rx queue has a byte
    localparam int ST_TX_FULL      = 1;   // tx queue holds FIFO_DEPTH bytes
    localparam int ST_TX_ACTIVE    = 2;   // frame going out
    localparam int ST_FRAMING      = 3;   // sticky, bad start or stop bit
    localparam int ST_RX_OVERFLOW  = 4;   // sticky, byte lost on rx side
    localparam int ST_RX_UNDERFLOW = 5;   // sticky, pop from empty rx queue
    localparam int ST_TX_OVERFLOW  = 6;   // sticky, push to full tx queue
    // bit 7 reads zero

endpackage

`default_nettype wire
